// ==== rtl/backend_pkg.sv ====
// shared widths, encodings and stage payloads for the pipeline back end
// imported by every back-end module and by the testbench
package backend_pkg;

    // data and address word
    typedef logic [31:0] word_t;
    // register file index
    typedef logic [4:0] reg_idx_t;

    // jal and jalr always write here
    localparam reg_idx_t LINK_REG = 5'd31;
    // local data memory size, word addressed
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW = 8;

    // alu functions
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    // execute result mux select
    typedef enum logic [1:0] {
        RES_ALU  = 2'd0,
        RES_SLT  = 2'd1,
        RES_SLTU = 2'd2,
        RES_LINK = 2'd3
    } res_sel_e;

    // memory access kind, none for non-memory ops
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LW   = 4'd1,
        MEM_LB   = 4'd2,
        MEM_LBU  = 4'd3,
        MEM_LH   = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SW   = 4'd6,
        MEM_SB   = 4'd7,
        MEM_SH   = 4'd8
    } mem_op_e;

    // branch kind, jal and jalr are j and jr with RES_LINK
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_J    = 4'd1,
        BR_JR   = 4'd2,
        BR_BEQ  = 4'd3,
        BR_BNE  = 4'd4,
        BR_BGEZ = 4'd5,
        BR_BLTZ = 4'd6,
        BR_BLEZ = 4'd7,
        BR_BGTZ = 4'd8
    } br_op_e;

    typedef enum logic [1:0] {
        EXC_NONE     = 2'd0,
        EXC_OVERFLOW = 2'd1,
        EXC_MISALIGN = 2'd2
    } exc_cause_e;

    // decoded op with operands already read, 150 bits
    typedef struct packed {
        word_t      pc;
        word_t      da;
        word_t      db;
        // sign-extended imm, shamt in 10:6, jump index in 25:0
        word_t      imm;
        reg_idx_t   rd;
        logic       reg_write;
        alu_op_e    alu_op;
        res_sel_e   res_sel;
        logic       use_imm;
        logic       shift_imm;
        mem_op_e    mem_op;
        br_op_e     br_op;
    } uop_t;

    // register write-back, 37 bits
    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    // exception report, 34 bits
    typedef struct packed {
        exc_cause_e cause;
        word_t      pc;
    } exc_t;

endpackage

// ==== rtl/alu_exec.sv ====
// execute stage datapath: operand select, alu, set-less-than and link address
// purely combinational, fed from the E pipeline register
module alu_exec (
    input  backend_pkg::uop_t       i_op,
    output backend_pkg::word_t      o_result,
    output backend_pkg::reg_idx_t   o_rd,
    output backend_pkg::exc_cause_e o_cause
);
    import backend_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t sum;
    word_t diff;
    word_t alu_out;
    word_t link_pc;
    logic  add_ovf;
    logic  sub_ovf;
    logic  lt_signed;
    logic  lt_unsigned;

    // shift amount comes from the immediate for sll/srl/sra
    assign op_a = i_op.shift_imm ? {27'b0, i_op.imm[10:6]} : i_op.da;
    assign op_b = i_op.use_imm ? i_op.imm : i_op.db;

    assign sum = op_a + op_b;
    assign diff = op_a - op_b;

    // same-sign inputs, result flips sign
    assign add_ovf = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
    // opposite-sign inputs, result takes sign of b
    assign sub_ovf = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);

    assign lt_signed = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // no delay slot, return to the next sequential op
    assign link_pc = i_op.pc + 32'd4;

    always_comb begin
        case (i_op.alu_op)
            ALU_ADD, ALU_ADDU: alu_out = sum;
            ALU_SUB, ALU_SUBU: alu_out = diff;
            ALU_AND:           alu_out = op_a & op_b;
            ALU_OR:            alu_out = op_a | op_b;
            ALU_XOR:           alu_out = op_a ^ op_b;
            ALU_NOR:           alu_out = ~(op_a | op_b);
            // shifted value is b, amount is a
            ALU_SLL:           alu_out = op_b << op_a[4:0];
            ALU_SRL:           alu_out = op_b >> op_a[4:0];
            ALU_SRA:           alu_out = word_t'($signed(op_b) >>> op_a[4:0]);
            ALU_LUI:           alu_out = {op_b[15:0], 16'b0};
            default:           alu_out = '0;
        endcase
    end

    // result mux
    always_comb begin
        case (i_op.res_sel)
            RES_SLT:  o_result = {31'b0, lt_signed};
            RES_SLTU: o_result = {31'b0, lt_unsigned};
            RES_LINK: o_result = link_pc;
            default:  o_result = alu_out;
        endcase
    end

    // link ops always target r31
    assign o_rd = (i_op.res_sel == RES_LINK) ? LINK_REG : i_op.rd;

    // only trapping add/sub, and only when their sum is the result
    always_comb begin
        o_cause = EXC_NONE;
        if (i_op.res_sel == RES_ALU) begin
            if ((i_op.alu_op == ALU_ADD && add_ovf) || (i_op.alu_op == ALU_SUB && sub_ovf)) begin
                o_cause = EXC_OVERFLOW;
            end
        end
    end

endmodule

// ==== rtl/branch_resolve.sv ====
// resolves the branch in E and checks it against the pc of the following op
// combinational; the top level qualifies o_miss with E valid/canceled
module branch_resolve (
    input  backend_pkg::uop_t  i_op,
    input  backend_pkg::word_t i_next_pc,
    input  logic               i_next_valid,
    output logic               o_miss,
    output backend_pkg::word_t o_target
);
    import backend_pkg::*;

    word_t pc_plus4;
    word_t jump_pc;
    word_t branch_pc;
    logic  rs_zero;
    logic  rs_neg;
    logic  rs_eq_rt;
    logic  taken;
    logic  is_branch;

    assign pc_plus4 = i_op.pc + 32'd4;
    // region bits from the branch itself
    assign jump_pc = {i_op.pc[31:28], i_op.imm[25:0], 2'b00};
    assign branch_pc = pc_plus4 + {i_op.imm[29:0], 2'b00};

    assign rs_zero = (i_op.da == '0);
    assign rs_neg = i_op.da[31];
    assign rs_eq_rt = (i_op.da == i_op.db);

    // condition per branch kind
    always_comb begin
        case (i_op.br_op)
            BR_BEQ:  taken = rs_eq_rt;
            BR_BNE:  taken = !rs_eq_rt;
            BR_BGEZ: taken = !rs_neg;
            BR_BLTZ: taken = rs_neg;
            BR_BLEZ: taken = rs_neg || rs_zero;
            BR_BGTZ: taken = !rs_neg && !rs_zero;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (i_op.br_op)
            BR_J:    o_target = jump_pc;
            BR_JR:   o_target = i_op.da;
            default: o_target = taken ? branch_pc : pc_plus4;
        endcase
    end

    assign is_branch = (i_op.br_op != BR_NONE);

    // empty follower slot counts as a miss too
    assign o_miss = is_branch && (!i_next_valid || (i_next_pc != o_target));

endmodule

// ==== rtl/data_ram.sv ====
// local word-addressed data memory, one read and one write port
// read data one cycle after the address; same-cycle write is forwarded
module data_ram (
    input  logic                           clk,
    input  logic [backend_pkg::RAM_AW-1:0] i_raddr,
    input  logic [backend_pkg::RAM_AW-1:0] i_waddr,
    input  logic                           i_we,
    input  backend_pkg::word_t             i_wdata,
    output backend_pkg::word_t             o_rdata
);
    import backend_pkg::*;

    word_t mem [0:RAM_WORDS-1];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // store in M, load of same word in E
    always_ff @(posedge clk) begin
        if (i_we && (i_waddr == i_raddr)) begin
            o_rdata <= i_wdata;
        end else begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

// ==== rtl/mem_align.sv ====
// big-endian sub-word handling for the memory stage
// load extract/extend, store read-modify-write merge, alignment check
module mem_align (
    input  backend_pkg::mem_op_e    i_op,
    input  backend_pkg::word_t      i_addr,
    input  backend_pkg::word_t      i_store_data,
    input  backend_pkg::word_t      i_rdata,
    output backend_pkg::word_t      o_load,
    output backend_pkg::word_t      o_wdata,
    output logic                    o_we,
    output backend_pkg::exc_cause_e o_cause
);
    import backend_pkg::*;

    logic [1:0] offset;
    logic       is_byte;
    logic       is_half;
    logic       is_word;
    logic       is_store;
    logic       misaligned;
    logic [4:0] shift;
    word_t      mask;
    word_t      raw;

    assign offset = i_addr[1:0];

    // access size and direction
    always_comb begin
        is_byte = 1'b0;
        is_half = 1'b0;
        is_word = 1'b0;
        is_store = 1'b0;
        case (i_op)
            MEM_LB, MEM_LBU: is_byte = 1'b1;
            MEM_LH, MEM_LHU: is_half = 1'b1;
            MEM_LW:          is_word = 1'b1;
            MEM_SB: begin
                is_byte = 1'b1;
                is_store = 1'b1;
            end
            MEM_SH: begin
                is_half = 1'b1;
                is_store = 1'b1;
            end
            MEM_SW: begin
                is_word = 1'b1;
                is_store = 1'b1;
            end
            default: ;
        endcase
    end

    // byte 0 sits in bits 31:24
    always_comb begin
        if (is_byte) begin
            shift = {2'd3 - offset, 3'b000};
            mask = 32'h0000_00ff << shift;
        end else if (is_half) begin
            shift = offset[1] ? 5'd0 : 5'd16;
            mask = 32'h0000_ffff << shift;
        end else begin
            shift = 5'd0;
            mask = '1;
        end
    end

    // lane moved down to bit 0
    assign raw = (i_rdata & mask) >> shift;

    always_comb begin
        case (i_op)
            MEM_LB:  o_load = {{24{raw[7]}}, raw[7:0]};
            MEM_LBU: o_load = {24'b0, raw[7:0]};
            MEM_LH:  o_load = {{16{raw[15]}}, raw[15:0]};
            MEM_LHU: o_load = {16'b0, raw[15:0]};
            default: o_load = raw;
        endcase
    end

    // old word outside the lane, new data inside
    assign o_wdata = (i_rdata & ~mask) | ((i_store_data << shift) & mask);

    assign misaligned = (is_half && offset[0]) || (is_word && (offset != 2'b00));

    // misaligned store leaves memory alone
    assign o_we = is_store && !misaligned;
    assign o_cause = misaligned ? EXC_MISALIGN : EXC_NONE;

endmodule

// ==== rtl/cpu_backend.sv ====
// execute, memory and write-back stages with their pipeline registers
// one op per cycle in; write-back, exception and redirect strobes out
module cpu_backend (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_valid,
    input  backend_pkg::uop_t  i_op,
    output logic               o_wb_en,
    output backend_pkg::wb_t   o_wb,
    output logic               o_exc_en,
    output backend_pkg::exc_t  o_exc,
    output logic               o_redirect,
    output backend_pkg::word_t o_redirect_pc
);
    import backend_pkg::*;

    // E to M payload
    typedef struct packed {
        word_t      result;
        word_t      db;
        reg_idx_t   rd;
        logic       reg_write;
        mem_op_e    mem_op;
        word_t      pc;
        exc_cause_e cause;
    } m_stage_t;

    logic       e_valid;
    logic       e_canceled;
    uop_t       e_op;
    logic       e_live;
    word_t      exe_result;
    reg_idx_t   exe_rd;
    exc_cause_e exe_cause;
    logic       br_miss;
    word_t      br_target;
    logic       flush;

    logic       m_valid;
    m_stage_t   m_q;
    word_t      ram_rdata;
    word_t      load_data;
    word_t      store_word;
    logic       store_we;
    exc_cause_e align_cause;
    exc_cause_e m_cause;
    logic       m_exc;
    logic       m_is_store;
    logic       m_is_load;

    // E stage
    assign e_live = e_valid && !e_canceled;

    alu_exec u_exec (
        .i_op     (e_op),
        .o_result (exe_result),
        .o_rd     (exe_rd),
        .o_cause  (exe_cause)
    );

    branch_resolve u_branch (
        .i_op         (e_op),
        .i_next_pc    (i_op.pc),
        .i_next_valid (i_valid),
        .o_miss       (br_miss),
        .o_target     (br_target)
    );

    // mispredict kills the op being sampled this edge
    assign flush = e_live && br_miss;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            e_valid <= 1'b0;
            e_canceled <= 1'b0;
            m_valid <= 1'b0;
            o_redirect <= 1'b0;
        end else begin
            e_valid <= i_valid;
            e_canceled <= flush;
            // canceled ops stop here
            m_valid <= e_live;
            o_redirect <= flush;
        end
    end

    always_ff @(posedge clk) begin
        e_op <= i_op;
        o_redirect_pc <= br_target;
        m_q.result <= exe_result;
        m_q.db <= e_op.db;
        m_q.rd <= exe_rd;
        m_q.reg_write <= e_op.reg_write;
        m_q.mem_op <= e_op.mem_op;
        m_q.pc <= e_op.pc;
        m_q.cause <= exe_cause;
    end

    // M stage, ram read launched from E so data lands in M
    data_ram u_ram (
        .clk     (clk),
        .i_raddr (exe_result[RAM_AW+1:2]),
        .i_waddr (m_q.result[RAM_AW+1:2]),
        .i_we    (m_valid && store_we && (m_q.cause == EXC_NONE)),
        .i_wdata (store_word),
        .o_rdata (ram_rdata)
    );

    mem_align u_align (
        .i_op         (m_q.mem_op),
        .i_addr       (m_q.result),
        .i_store_data (m_q.db),
        .i_rdata      (ram_rdata),
        .o_load       (load_data),
        .o_wdata      (store_word),
        .o_we         (store_we),
        .o_cause      (align_cause)
    );

    // execute trap wins over alignment
    assign m_cause = (m_q.cause != EXC_NONE) ? m_q.cause : align_cause;
    assign m_exc = m_valid && (m_cause != EXC_NONE);

    assign m_is_store = m_q.mem_op inside {MEM_SW, MEM_SH, MEM_SB};
    assign m_is_load = m_q.mem_op inside {MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};

    // W output registers
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb_en <= 1'b0;
            o_exc_en <= 1'b0;
        end else begin
            o_wb_en <= m_valid && !m_exc && m_q.reg_write && !m_is_store;
            o_exc_en <= m_exc;
        end
    end

    always_ff @(posedge clk) begin
        o_wb.rd <= m_q.rd;
        o_wb.data <= m_is_load ? load_data : m_q.result;
        o_exc.cause <= m_cause;
        o_exc.pc <= m_q.pc;
    end

endmodule

// ==== verif/clk_gen.sv ====
// free-running testbench clock, 4 ns period
module clk_gen (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
    end

    // half period
    always #2 o_clk = ~o_clk;

endmodule

// ==== verif/cpu_backend_checker.sv ====
// protocol assertions on the back-end output strobes
// attached to every cpu_backend instance through the bind below
module cpu_backend_checker (
    input logic clk,
    input logic i_rst,
    input logic i_wb_en,
    input logic i_exc_en,
    input logic i_redirect
);
    timeunit 1ns;
    timeprecision 100ps;

    // first cycle out of reset is quiet
    assert property (@(posedge clk) $fell(i_rst) |=> !i_wb_en && !i_exc_en && !i_redirect)
        else $error("output strobe high right after reset");

    // an op either writes back or traps
    assert property (@(posedge clk) disable iff (i_rst) !(i_wb_en && i_exc_en))
        else $error("write-back and exception strobes high together");

    // squashed follower can never redirect again
    assert property (@(posedge clk) disable iff (i_rst) i_redirect |=> !i_redirect)
        else $error("redirect high in two consecutive cycles");

endmodule

bind cpu_backend cpu_backend_checker u_checker (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_wb_en    (o_wb_en),
    .i_exc_en   (o_exc_en),
    .i_redirect (o_redirect)
);

// ==== verif/tb_cpu_backend.sv ====
// random-stimulus testbench for the back end with a cycle-stamped reference model
// runs alu, overflow, memory, misalignment and branch tests, then reports counts
module tb_cpu_backend;
    timeunit 1ns;
    timeprecision 100ps;
    import backend_pkg::*;

    localparam int ALU_OPS = 60;
    localparam int OVF_OPS = 20;
    localparam int MEM_OPS = 80;
    localparam int MIS_OPS = 16;
    localparam int BR_ITEMS = 60;
    // worst-case slot count, each test may double its ops plus drain
    localparam int TOTAL_SLOTS = ALU_OPS * 2 + OVF_OPS + RAM_WORDS + MEM_OPS * 2
                               + MIS_OPS * 2 + BR_ITEMS * 2 + 5 * 6 + 10;
    localparam int TIMEOUT_NS = TOTAL_SLOTS * 4 + 400;

    typedef struct packed {
        logic [31:0] stamp;
        wb_t         v;
    } wb_exp_t;

    typedef struct packed {
        logic [31:0] stamp;
        exc_t        v;
    } exc_exp_t;

    typedef struct packed {
        logic [31:0] stamp;
        word_t       v;
    } pc_exp_t;

    logic  clk;
    logic  i_rst;
    logic  i_valid;
    uop_t  i_op;
    logic  o_wb_en;
    wb_t   o_wb;
    logic  o_exc_en;
    exc_t  o_exc;
    logic  o_redirect;
    word_t o_redirect_pc;

    integer      seed = 32'h5ac6005f;
    logic [31:0] edge_cnt = '0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_err0;
    string       cur_test = "reset";
    word_t       next_pc = 32'h0040_0000;

    // model state
    word_t    model_mem [0:RAM_WORDS-1];
    wb_exp_t  wb_q[$];
    exc_exp_t exc_q[$];
    pc_exp_t  rd_q[$];
    logic     pend_br = 1'b0;
    word_t    pend_target;

    clk_gen u_clk (.o_clk(clk));

    cpu_backend dut0 (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_valid       (i_valid),
        .i_op          (i_op),
        .o_wb_en       (o_wb_en),
        .o_wb          (o_wb),
        .o_exc_en      (o_exc_en),
        .o_exc         (o_exc),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    always @(posedge clk) edge_cnt <= edge_cnt + 32'd1;

    function automatic word_t rnd();
        return word_t'($random(seed));
    endfunction

    // reference operands and results
    function automatic word_t operand_a(uop_t op);
        return op.shift_imm ? {27'b0, op.imm[10:6]} : op.da;
    endfunction

    function automatic word_t operand_b(uop_t op);
        return op.use_imm ? op.imm : op.db;
    endfunction

    function automatic word_t alu_ref(uop_t op);
        word_t a;
        word_t b;
        a = operand_a(op);
        b = operand_b(op);
        case (op.alu_op)
            ALU_ADD, ALU_ADDU: return a + b;
            ALU_SUB, ALU_SUBU: return a - b;
            ALU_AND:           return a & b;
            ALU_OR:            return a | b;
            ALU_XOR:           return a ^ b;
            ALU_NOR:           return ~(a | b);
            ALU_SLL:           return b << a[4:0];
            ALU_SRL:           return b >> a[4:0];
            ALU_SRA:           return word_t'($signed(b) >>> a[4:0]);
            default:           return {b[15:0], 16'h0000};
        endcase
    endfunction

    // 64-bit signed result out of the 32-bit range
    function automatic logic overflows(uop_t op);
        longint s;
        if (op.res_sel != RES_ALU) return 1'b0;
        if (op.alu_op == ALU_ADD) begin
            s = longint'($signed(operand_a(op))) + longint'($signed(operand_b(op)));
        end else if (op.alu_op == ALU_SUB) begin
            s = longint'($signed(operand_a(op))) - longint'($signed(operand_b(op)));
        end else begin
            return 1'b0;
        end
        return (s > 64'sd2147483647) || (s < -64'sd2147483648);
    endfunction

    function automatic word_t exec_ref(uop_t op);
        case (op.res_sel)
            RES_SLT:  return {31'b0, $signed(operand_a(op)) < $signed(operand_b(op))};
            RES_SLTU: return {31'b0, operand_a(op) < operand_b(op)};
            RES_LINK: return op.pc + 32'd4;
            default:  return alu_ref(op);
        endcase
    endfunction

    function automatic logic misaligned_ref(mem_op_e m, word_t addr);
        case (m)
            MEM_LW, MEM_SW:          return addr[1:0] != 2'b00;
            MEM_LH, MEM_LHU, MEM_SH: return addr[0];
            default:                 return 1'b0;
        endcase
    endfunction

    // byte i of a big-endian word, byte 0 on top
    function automatic logic [7:0] byte_at(word_t w, logic [1:0] i);
        return w[31 - 8 * i -: 8];
    endfunction

    function automatic word_t load_ref(mem_op_e m, word_t addr, word_t w);
        logic [15:0] h;
        logic [7:0]  b;
        b = byte_at(w, addr[1:0]);
        h = {byte_at(w, addr[1:0]), byte_at(w, addr[1:0] + 2'd1)};
        case (m)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'b0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'b0, h};
            default: return w;
        endcase
    endfunction

    function automatic word_t store_ref(mem_op_e m, word_t addr, word_t old, word_t d);
        word_t n;
        n = old;
        case (m)
            MEM_SB:  n[31 - 8 * addr[1:0] -: 8] = d[7:0];
            MEM_SH:  n[31 - 8 * addr[1:0] -: 16] = d[15:0];
            default: n = d;
        endcase
        return n;
    endfunction

    function automatic word_t target_ref(uop_t op);
        logic  t;
        word_t seq;
        seq = op.pc + 32'd4;
        case (op.br_op)
            BR_J:    return {op.pc[31:28], op.imm[25:0], 2'b00};
            BR_JR:   return op.da;
            BR_BEQ:  t = op.da == op.db;
            BR_BNE:  t = op.da != op.db;
            BR_BGEZ: t = $signed(op.da) >= 0;
            BR_BLTZ: t = $signed(op.da) < 0;
            BR_BLEZ: t = $signed(op.da) <= 0;
            default: t = $signed(op.da) > 0;
        endcase
        return t ? seq + (op.imm << 2) : seq;
    endfunction

    // one slot of the model, k is the edge that samples it
    task automatic model_slot(input logic valid, input uop_t op, input logic [31:0] k);
        logic       canceled;
        word_t      res;
        exc_cause_e cause;
        logic       is_store;
        logic       is_load;
        wb_t        w;
        canceled = 1'b0;
        if (pend_br) begin
            if (!valid || op.pc != pend_target) begin
                rd_q.push_back('{stamp: k, v: pend_target});
                canceled = 1'b1;
            end
            pend_br = 1'b0;
        end
        if (valid && !canceled) begin
            res = exec_ref(op);
            is_store = op.mem_op inside {MEM_SW, MEM_SH, MEM_SB};
            is_load = op.mem_op inside {MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};
            cause = EXC_NONE;
            if (overflows(op)) begin
                cause = EXC_OVERFLOW;
            end else if (misaligned_ref(op.mem_op, res)) begin
                cause = EXC_MISALIGN;
            end
            if (op.br_op != BR_NONE) begin
                pend_br = 1'b1;
                pend_target = target_ref(op);
            end
            if (cause != EXC_NONE) begin
                exc_q.push_back('{stamp: k + 32'd2, v: '{cause: cause, pc: op.pc}});
            end else if (is_store) begin
                model_mem[res[RAM_AW+1:2]] = store_ref(op.mem_op, res,
                                                       model_mem[res[RAM_AW+1:2]], op.db);
            end else if (op.reg_write) begin
                w.rd = (op.res_sel == RES_LINK) ? LINK_REG : op.rd;
                w.data = is_load ? load_ref(op.mem_op, res, model_mem[res[RAM_AW+1:2]]) : res;
                wb_q.push_back('{stamp: k + 32'd2, v: w});
            end
        end
    endtask

    task automatic send_slot(input logic valid, input uop_t op);
        logic [31:0] k;
        @(posedge clk);
        k = edge_cnt + 32'd2;
        i_valid <= valid;
        i_op <= op;
        model_slot(valid, op, k);
    endtask

    task automatic new_op(output uop_t op);
        op = '0;
        op.alu_op = ALU_ADDU;
        op.res_sel = RES_ALU;
        op.pc = next_pc;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic compare_wb(input wb_t exp, input wb_t act);
        if (exp !== act) begin
            $display("MISMATCH %s wb expected %h actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic compare_exc(input exc_t exp, input exc_t act);
        if (exp !== act) begin
            $display("MISMATCH %s exc expected %h actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic compare_word(input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("MISMATCH %s redirect expected %h actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic report(input string what);
        $display("ERROR %s: %s at edge %0d", cur_test, what, edge_cnt);
        errors++;
    endtask

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (!i_rst) begin
            if (wb_q.size() > 0 && wb_q[0].stamp == edge_cnt) begin
                if (o_wb_en) compare_wb(wb_q[0].v, o_wb);
                else report("expected write-back did not come");
                void'(wb_q.pop_front());
            end else if (o_wb_en) begin
                report("unexpected write-back");
            end
            if (exc_q.size() > 0 && exc_q[0].stamp == edge_cnt) begin
                if (o_exc_en) compare_exc(exc_q[0].v, o_exc);
                else report("expected exception did not come");
                void'(exc_q.pop_front());
            end else if (o_exc_en) begin
                report("unexpected exception");
            end
            if (rd_q.size() > 0 && rd_q[0].stamp == edge_cnt) begin
                if (o_redirect) compare_word(rd_q[0].v, o_redirect_pc);
                else report("expected redirect did not come");
                void'(rd_q.pop_front());
            end else if (o_redirect) begin
                report("unexpected redirect");
            end
        end
    end

    task automatic start_test(input string name);
        cur_test = name;
        test_err0 = errors;
        tests_run++;
    endtask

    // idle slots flush the pipe, then nothing may be left over
    task automatic finish_test();
        repeat (5) send_slot(1'b0, '0);
        @(posedge clk);
        @(negedge clk);
        #1;
        if (wb_q.size() + exc_q.size() + rd_q.size() != 0) begin
            report("expected outputs never arrived");
            wb_q.delete();
            exc_q.delete();
            rd_q.delete();
        end
        if (errors != test_err0) tests_failed++;
        $display("test %s: %s", cur_test, (errors == test_err0) ? "ok" : "errors");
    endtask

    task automatic test_alu();
        uop_t  op;
        word_t r;
        start_test("alu");
        for (int i = 0; i < ALU_OPS; i++) begin
            new_op(op);
            r = rnd();
            op.alu_op = alu_op_e'(4'(r % 12));
            op.res_sel = res_sel_e'(2'((r >> 8) % 3));
            op.use_imm = r[12];
            op.shift_imm = r[13] && (op.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA});
            op.rd = r[20:16];
            op.reg_write = 1'b1;
            op.da = rnd();
            op.db = rnd();
            r = rnd();
            op.imm = {{16{r[15]}}, r[15:0]};
            send_slot(1'b1, op);
            if (r[31:29] == 3'b000) send_slot(1'b0, '0);
        end
        finish_test();
    endtask

    task automatic test_overflow();
        uop_t  op;
        word_t r;
        word_t ra;
        word_t rb;
        start_test("overflow");
        for (int i = 0; i < OVF_OPS; i++) begin
            new_op(op);
            r = rnd();
            op.reg_write = 1'b1;
            op.rd = r[4:0];
            op.alu_op = r[5] ? ALU_SUB : ALU_ADD;
            // both at least 2^30, or positive minus large negative
            ra = rnd();
            rb = rnd();
            op.da = {2'b01, ra[29:0]};
            op.db = r[5] ? {2'b10, rb[29:0]} : {2'b01, rb[29:0]};
            // a few that stay in range
            if (r[9:8] == 2'b00) op.db = {24'b0, r[31:24]};
            send_slot(1'b1, op);
        end
        finish_test();
    endtask

    task automatic mem_op(input mem_op_e m, input word_t addr, input word_t data);
        uop_t  op;
        word_t r;
        new_op(op);
        r = rnd();
        op.mem_op = m;
        op.use_imm = 1'b1;
        op.imm = {{26{r[5]}}, r[5:0]};
        op.da = addr - op.imm;
        op.db = data;
        op.rd = r[12:8];
        op.reg_write = !(m inside {MEM_SW, MEM_SH, MEM_SB});
        send_slot(1'b1, op);
    endtask

    task automatic test_memory();
        word_t      r;
        logic [7:0] w;
        mem_op_e    m;
        logic [1:0] off;
        start_test("memory");
        for (int i = 0; i < RAM_WORDS; i++) begin
            w = 8'(i);
            mem_op(MEM_SW, {22'b0, w, 2'b00}, {w ^ 8'ha5, w, ~w, w ^ 8'h3c});
        end
        for (int i = 0; i < MEM_OPS; i++) begin
            r = rnd();
            case (r % 8)
                0: m = MEM_LW;
                1: m = MEM_LB;
                2: m = MEM_LBU;
                3: m = MEM_LH;
                4: m = MEM_LHU;
                5: m = MEM_SW;
                6: m = MEM_SB;
                default: m = MEM_SH;
            endcase
            off = r[9:8];
            if (m inside {MEM_LH, MEM_LHU, MEM_SH}) off[0] = 1'b0;
            if (m inside {MEM_LW, MEM_SW}) off = 2'b00;
            mem_op(m, {22'b0, r[23:16], off}, rnd());
            // back-to-back read of the word just stored
            if (m inside {MEM_SW, MEM_SB, MEM_SH} && r[31]) begin
                mem_op(MEM_LW, {22'b0, r[23:16], 2'b00}, '0);
            end
        end
        finish_test();
    endtask

    task automatic test_misalign();
        word_t      r;
        mem_op_e    m;
        logic [1:0] off;
        start_test("misalign");
        for (int i = 0; i < MIS_OPS; i++) begin
            r = rnd();
            case (r % 5)
                0: m = MEM_LH;
                1: m = MEM_LHU;
                2: m = MEM_SH;
                3: m = MEM_LW;
                default: m = MEM_SW;
            endcase
            if (m inside {MEM_LW, MEM_SW}) off = 2'(((r >> 8) % 3) + 1);
            else off = {r[9], 1'b1};
            mem_op(m, {22'b0, r[23:16], off}, rnd());
            mem_op(MEM_LW, {22'b0, r[23:16], 2'b00}, '0);
        end
        finish_test();
    endtask

    task automatic test_branch();
        uop_t  br;
        uop_t  fol;
        word_t r;
        word_t idx;
        word_t target;
        start_test("branch");
        for (int i = 0; i < BR_ITEMS; i++) begin
            new_op(br);
            r = rnd();
            br.br_op = br_op_e'(4'((r % 8) + 1));
            br.da = rnd();
            br.db = rnd();
            if (r[5:4] == 2'b00) br.da = '0;
            if (r[5:4] == 2'b01) br.db = br.da;
            br.imm = {{26{r[13]}}, r[13:8]};
            if (br.br_op == BR_J) begin
                idx = rnd();
                br.imm = {6'b0, idx[25:0]};
            end
            if (br.br_op == BR_JR) br.da = {br.da[31:2], 2'b00};
            if (br.br_op inside {BR_J, BR_JR} && r[6]) begin
                br.res_sel = RES_LINK;
                br.reg_write = 1'b1;
                br.rd = r[20:16];
            end
            target = target_ref(br);
            send_slot(1'b1, br);
            r = rnd();
            if (r[2:0] == 3'b000) begin
                send_slot(1'b0, '0);
                next_pc = target;
            end else begin
                next_pc = r[3] ? target : target + {26'b0, r[7:4], 2'b00} + 32'd4;
                new_op(fol);
                fol.da = rnd();
                fol.db = rnd();
                fol.rd = r[12:8];
                fol.reg_write = 1'b1;
                send_slot(1'b1, fol);
            end
        end
        finish_test();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        i_rst = 1'b1;
        i_valid = 1'b0;
        i_op = '0;
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;
        test_alu();
        test_overflow();
        test_memory();
        test_misalign();
        test_branch();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/backend_pkg.sv
rtl/alu_exec.sv
rtl/branch_resolve.sv
rtl/data_ram.sv
rtl/mem_align.sv
rtl/cpu_backend.sv
verif/clk_gen.sv
verif/cpu_backend_checker.sv
verif/tb_cpu_backend.sv

// ==== run.sh ====
#!/bin/bash
# build and run the back-end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cpu_backend -f tb.f -o sim_tb \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1
